// File: design/flitFifo.sv
`timescale 1ns/10ps

module flitFifo (
  input  logic             clk,
  input  logic             rst,
  input  logic             inValid,
  output logic             inReady,
  input  flitPkg::flitIdT   inFlitId,
  input  flitPkg::flitDataT inData,
  output logic             headValid,
  output flitPkg::flitIdT   headFlitId,
  output flitPkg::flitDataT headData,
  input  logic             headPop
);

  flitPkg::flitIdT   idMem [portPkg::fifoDepth];
  flitPkg::flitDataT dataMem [portPkg::fifoDepth];

  logic [$clog2(portPkg::fifoDepth)-1:0] wrPtr;
  logic [$clog2(portPkg::fifoDepth)-1:0] rdPtr;
  logic [$clog2(portPkg::fifoDepth+1)-1:0] count;
  logic push;

  assign inReady = (count != portPkg::fifoDepth);
  assign headValid = (count != 0);
  assign push = inValid && inReady;

  assign headFlitId = idMem[rdPtr];
  assign headData = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= (int'(wrPtr) == portPkg::fifoDepth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (headPop)
      begin
        rdPtr <= (int'(rdPtr) == portPkg::fifoDepth - 1) ? '0 : rdPtr + 1'b1;
      end
      // simultaneous push and pop leaves the count unchanged.
      case ({push, headPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      idMem[wrPtr] <= inFlitId;
      dataMem[wrPtr] <= inData;
    end
  end

  // arbiter only pops a flit that is present.
  popNeedsHead: assert property (@(posedge clk) disable iff (rst) headPop |-> headValid);

endmodule

// File: design/flitPkg.sv
package flitPkg;

  // flit type codes carried next to each payload word.
  typedef logic [2:0] flitIdT;

  localparam flitIdT idHead = 3'd1;
  localparam flitIdT idBody = 3'd2;
  localparam flitIdT idTail = 3'd3;

  localparam int dataWidth = 32;

  // header payload carries the packet length in its low bits.
  // the length counts every flit, header included.
  localparam int lengthWidth = 12;

  typedef logic [dataWidth-1:0] flitDataT;

endpackage

// File: design/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [portPkg::numPorts-1:0]                headValid,
  input  flitPkg::flitIdT [portPkg::numPorts-1:0]     headFlitId,
  input  flitPkg::flitDataT [portPkg::numPorts-1:0]   headData,
  output logic [portPkg::numPorts-1:0]                headPop,
  output logic                                        outValid,
  input  logic                                        outReady,
  output flitPkg::flitIdT                             outFlitId,
  output flitPkg::flitDataT                           outData,
  output portPkg::portIdxT                            outSource
);

  // bit 0 is the idle code, bit i+1 grants channel i.
  logic [portPkg::numPorts:0] grant;
  logic [portPkg::numPorts:0] nextGrant;

  logic [portPkg::numPorts-1:0] packetDone;
  portPkg::portIdxT holderIdx;
  portPkg::portIdxT startIdx;
  logic started;
  logic hold;
  logic outFree;
  logic popEn;

  genvar i;
  generate
    for (i = 0; i < portPkg::numPorts; i++)
    begin : budgetGen
      packetBudget budgetInst (
        .clk        (clk),
        .rst        (rst),
        .load       (headPop[i] && (headFlitId[i] == flitPkg::idHead)),
        .length     (headData[i][flitPkg::lengthWidth-1:0]),
        .step       (headPop[i]),
        .packetDone (packetDone[i])
      );
      assign headPop[i] = popEn && grant[i + 1];
    end
  endgenerate

  always_comb
  begin
    holderIdx = portPkg::portL;
    for (int k = 0; k < portPkg::numPorts; k++)
    begin
      if (grant[k + 1])
      begin
        holderIdx = portPkg::portIdxT'(k);
      end
    end
  end

  // a stale done from the last packet is ignored until this grant pops.
  assign hold = !grant[0] && headValid[holderIdx] && !(started && packetDone[holderIdx]);
  assign outFree = !outValid || outReady;
  assign popEn = hold && outFree;

  // from idle, start after S so that L is checked first.
  assign startIdx = grant[0] ? portPkg::portS : holderIdx;

  always_comb
  begin
    int idx;
    logic found;
    nextGrant = grant;
    found = 1'b0;
    idx = 0;
    if (!hold)
    begin
      nextGrant = {{portPkg::numPorts{1'b0}}, 1'b1};
      // holder itself comes last in the rotation.
      for (int k = 1; k <= portPkg::numPorts; k++)
      begin
        idx = (int'(startIdx) + k) % portPkg::numPorts;
        if (!found && headValid[idx])
        begin
          nextGrant = '0;
          nextGrant[idx + 1] = 1'b1;
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= {{portPkg::numPorts{1'b0}}, 1'b1};
      started <= 1'b0;
      outValid <= 1'b0;
    end
    else
    begin
      grant <= nextGrant;
      if (!hold)
      begin
        started <= 1'b0;
      end
      else if (popEn)
      begin
        started <= 1'b1;
      end
      if (outFree)
      begin
        outValid <= popEn;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (popEn)
    begin
      outFlitId <= headFlitId[holderIdx];
      outData <= headData[holderIdx];
      outSource <= holderIdx;
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant));

  // a stalled output must not change under the receiver.
  outHeldOnStall: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outData)));

endmodule

// File: design/outputPort.sv
`timescale 1ns/10ps

module outputPort (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic [portPkg::numPorts-1:0]              inValid,
  output logic [portPkg::numPorts-1:0]              inReady,
  input  flitPkg::flitIdT [portPkg::numPorts-1:0]   inFlitId,
  input  flitPkg::flitDataT [portPkg::numPorts-1:0] inData,
  output logic                                      outValid,
  input  logic                                      outReady,
  output flitPkg::flitIdT                           outFlitId,
  output flitPkg::flitDataT                         outData,
  output portPkg::portIdxT                          outSource
);

  logic [portPkg::numPorts-1:0] headValid;
  flitPkg::flitIdT [portPkg::numPorts-1:0] headFlitId;
  flitPkg::flitDataT [portPkg::numPorts-1:0] headData;
  logic [portPkg::numPorts-1:0] headPop;

  genvar i;
  generate
    for (i = 0; i < portPkg::numPorts; i++)
    begin : fifoGen
      flitFifo fifoInst (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid[i]),
        .inReady    (inReady[i]),
        .inFlitId   (inFlitId[i]),
        .inData     (inData[i]),
        .headValid  (headValid[i]),
        .headFlitId (headFlitId[i]),
        .headData   (headData[i]),
        .headPop    (headPop[i])
      );
    end
  endgenerate

  outputArbiter arbiterInst (
    .clk        (clk),
    .rst        (rst),
    .headValid  (headValid),
    .headFlitId (headFlitId),
    .headData   (headData),
    .headPop    (headPop),
    .outValid   (outValid),
    .outReady   (outReady),
    .outFlitId  (outFlitId),
    .outData    (outData),
    .outSource  (outSource)
  );

endmodule

// File: design/packetBudget.sv
`timescale 1ns/10ps

module packetBudget (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            load,
  input  logic [flitPkg::lengthWidth-1:0] length,
  input  logic                            step,
  output logic                            packetDone
);

  logic [flitPkg::lengthWidth-1:0] lengthReg;
  logic [flitPkg::lengthWidth-1:0] sentCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lengthReg <= '0;
      sentCount <= '0;
    end
    else if (load)
    begin
      // the header itself is the first flit sent.
      lengthReg <= length;
      sentCount <= 1;
    end
    else if (step)
    begin
      sentCount <= sentCount + 1'b1;
    end
  end

  // counts flits sent, not cycles, so stalls never end a packet early.
  assign packetDone = (sentCount == lengthReg);

endmodule

// File: design/portPkg.sv
package portPkg;

  localparam int numPorts = 5;

  typedef logic [2:0] portIdxT;

  // channel indices, also the arbitration rotation order.
  localparam portIdxT portL = 3'd0;
  localparam portIdxT portN = 3'd1;
  localparam portIdxT portE = 3'd2;
  localparam portIdxT portW = 3'd3;
  localparam portIdxT portS = 3'd4;

  // input buffer depth in flits.
  localparam int fifoDepth = 4;

endpackage

// File: outputPort.f
design/flitPkg.sv
design/portPkg.sv
design/flitFifo.sv
design/packetBudget.sv
design/outputArbiter.sv
design/outputPort.sv
+incdir+tb
tb/outputPortTb.sv

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f outputPort.f \
  --top-module outputPortTb \
  -o simOutputPort

./obj_dir/simOutputPort | tee sim.log

if grep -qx "Done: no errors" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb/outputPortTests.svh
task automatic compareFlag(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    mismatchCount++;
    $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  end
endtask

task automatic compareFlitId(input string name, input flitPkg::flitIdT got,
                             input flitPkg::flitIdT exp);
  if (got !== exp)
  begin
    mismatchCount++;
    $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  end
endtask

task automatic compareData(input string name, input flitPkg::flitDataT got,
                           input flitPkg::flitDataT exp);
  if (got !== exp)
  begin
    mismatchCount++;
    $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  end
endtask

task automatic compareSource(input string name, input portPkg::portIdxT got,
                             input portPkg::portIdxT exp);
  if (got !== exp)
  begin
    mismatchCount++;
    $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  end
endtask

// header carries a serial number above the length field.
task automatic sendPacket(input portPkg::portIdxT ch, input int len);
  flitPkg::flitIdT id;
  flitPkg::flitDataT data;
  @(posedge clk);
  serial++;
  for (int k = 0; k < len; k++)
  begin
    if (k == 0)
    begin
      id = flitPkg::idHead;
      data = (flitPkg::flitDataT'(serial) << 16) | flitPkg::flitDataT'(len);
    end
    else
    begin
      id = (k == len - 1) ? flitPkg::idTail : flitPkg::idBody;
      data = $urandom();
    end
    inValid[ch] <= 1'b1;
    inFlitId[ch] <= id;
    inData[ch] <= data;
    // ready seen at mid cycle means the flit is taken on the next edge.
    do @(negedge clk); while (!inReady[ch]);
    @(posedge clk);
    expId[ch].push_back(id);
    expData[ch].push_back(data);
  end
  inValid[ch] <= 1'b0;
endtask

task automatic sendRandomPackets(input portPkg::portIdxT ch);
  for (int p = 0; p < 4; p++)
    sendPacket(ch, int'($urandom_range(8, 1)));
endtask

task automatic waitDrain();
  int waited;
  bit busy;
  waited = 0;
  busy = 1'b1;
  while (busy && waited < 300)
  begin
    @(posedge clk);
    waited++;
    busy = 1'b0;
    for (int c = 0; c < portPkg::numPorts; c++)
      if (expId[c].size() != 0)
        busy = 1'b1;
  end
  if (busy)
  begin
    failureCount++;
    $display("flits were still missing %0d cycles after the last was sent", waited);
  end
endtask

task automatic waitForHeader();
  int waited;
  waited = 0;
  while (headerOrder.size() == 0 && waited < 50)
  begin
    @(posedge clk);
    waited++;
  end
  if (headerOrder.size() == 0)
  begin
    failureCount++;
    $display("no header reached the output within %0d cycles", waited);
  end
endtask

task automatic checkOrder();
  if (headerOrder.size() != expOrder.size())
  begin
    failureCount++;
    $display("saw %0d packets where %0d were expected", headerOrder.size(), expOrder.size());
  end
  else
  begin
    for (int k = 0; k < expOrder.size(); k++)
      compareSource("packet source", headerOrder[k], expOrder[k]);
  end
  headerOrder.delete();
  expOrder.delete();
endtask

task automatic singleNorthPacket();
  @(negedge clk);
  compareFlag("outValid", outValid, 1'b0);
  for (int c = 0; c < portPkg::numPorts; c++)
    compareFlag($sformatf("inReady[%0d]", c), inReady[c], 1'b1);
  sendPacket(portPkg::portN, 5);
  waitDrain();
  expOrder.push_back(portPkg::portN);
  checkOrder();
endtask

task automatic allChannelsAtOnce();
  fork
    sendPacket(portPkg::portL, 3);
    sendPacket(portPkg::portN, 4);
    sendPacket(portPkg::portE, 5);
    sendPacket(portPkg::portW, 6);
    sendPacket(portPkg::portS, 7);
  join
  waitDrain();
  for (int c = 0; c < portPkg::numPorts; c++)
    expOrder.push_back(portPkg::portIdxT'(c));
  checkOrder();
endtask

// L and S arrive while N still holds the output.
task automatic rotationAfterNorth();
  fork
    sendPacket(portPkg::portN, 8);
    begin
      waitForHeader();
      fork
        sendPacket(portPkg::portL, 4);
        sendPacket(portPkg::portS, 4);
      join
    end
  join
  waitDrain();
  expOrder.push_back(portPkg::portN);
  expOrder.push_back(portPkg::portS);
  expOrder.push_back(portPkg::portL);
  checkOrder();
endtask

task automatic randomStalls();
  readyMode <= 2;
  fork
    sendRandomPackets(portPkg::portL);
    sendRandomPackets(portPkg::portN);
    sendRandomPackets(portPkg::portE);
    sendRandomPackets(portPkg::portW);
    sendRandomPackets(portPkg::portS);
  join
  waitDrain();
  readyMode <= 1;
  headerOrder.delete();
endtask

task automatic backPressure();
  int waited;
  bit dropped;
  readyMode <= 0;
  @(posedge clk);
  fork
    sendPacket(portPkg::portE, 9);
    begin
      waited = 0;
      dropped = 1'b0;
      while (!dropped && waited < 40)
      begin
        @(negedge clk);
        waited++;
        dropped = !inReady[portPkg::portE];
      end
      if (!dropped)
      begin
        failureCount++;
        $display("inReady on E stayed high with the output stalled");
      end
      readyMode <= 1;
    end
  join
  waitDrain();
  headerOrder.delete();
endtask

// a header-only packet on W must hand over to S before W sends again.
task automatic singleFlitPacket();
  fork
    begin
      sendPacket(portPkg::portW, 1);
      sendPacket(portPkg::portW, 3);
    end
    sendPacket(portPkg::portS, 3);
  join
  waitDrain();
  expOrder.push_back(portPkg::portW);
  expOrder.push_back(portPkg::portS);
  expOrder.push_back(portPkg::portW);
  checkOrder();
endtask

// File: tb/outputPortTb.sv
`timescale 1ns/10ps

module outputPortTb;

  // every flit the tests can send with random bursts at their longest.
  localparam int totalFlits = 5 + 25 + 16 + 5 * 4 * 8 + 9 + 7;
  localparam int testLength = 2 * totalFlits + 50;
  localparam int timeoutCycles = 4 * testLength;

  logic clk = 1'b0;
  logic rst;
  logic [portPkg::numPorts-1:0] inValid;
  logic [portPkg::numPorts-1:0] inReady;
  flitPkg::flitIdT [portPkg::numPorts-1:0] inFlitId;
  flitPkg::flitDataT [portPkg::numPorts-1:0] inData;
  logic outValid;
  logic outReady = 1'b0;
  flitPkg::flitIdT outFlitId;
  flitPkg::flitDataT outData;
  portPkg::portIdxT outSource;

  // 0 holds outReady low, 1 holds it high, 2 stalls at random.
  int readyMode = 1;
  int cycleCount = 0;
  int mismatchCount = 0;
  int failureCount = 0;
  int serial = 0;

  // one scoreboard queue pair per input channel.
  flitPkg::flitIdT expId[portPkg::numPorts][$];
  flitPkg::flitDataT expData[portPkg::numPorts][$];
  portPkg::portIdxT headerOrder[$];
  portPkg::portIdxT expOrder[$];
  portPkg::portIdxT pktSrc;
  int pktLeft = 0;

  outputPort outputPort_inst (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inReady   (inReady),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outSource (outSource)
  );

  `include "outputPortTests.svh"

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (readyMode == 2)
      outReady <= ($urandom_range(3, 0) != 0);
    else
      outReady <= (readyMode == 1);
  end

  task automatic checkOutput();
    int src;
    src = int'(outSource);
    if (src >= portPkg::numPorts)
    begin
      failureCount++;
      $display("output flit names channel %0d, which does not exist", src);
    end
    else if (expId[src].size() == 0)
    begin
      failureCount++;
      $display("channel %0d delivered a flit that was never sent", src);
    end
    else
    begin
      // inside a packet every flit must come from the header's channel.
      if (pktLeft > 0)
        compareSource("outSource", outSource, pktSrc);
      compareFlitId("outFlitId", outFlitId, expId[src].pop_front());
      compareData("outData", outData, expData[src].pop_front());
    end
    if (outFlitId == flitPkg::idHead)
    begin
      headerOrder.push_back(outSource);
      pktSrc = outSource;
      pktLeft = int'(outData[flitPkg::lengthWidth-1:0]) - 1;
    end
    else if (pktLeft > 0)
      pktLeft--;
  endtask

  // output transfers checked at mid cycle.
  always @(negedge clk)
  begin
    if (!rst && outValid && outReady)
      checkOutput();
  end

  task automatic finishReport();
    $display("errors: %0d value mismatches, %0d other failures", mismatchCount, failureCount);
    if (mismatchCount + failureCount > 0)
      $display("Done: errors found");
    else
      $display("Done: no errors");
  endtask

  initial
  begin
    void'($urandom(65));
    inValid <= '0;
    inFlitId <= '0;
    inData <= '0;
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    singleNorthPacket();
    allChannelsAtOnce();
    rotationAfterNorth();
    randomStalls();
    backPressure();
    singleFlitPacket();
    finishReport();
    $finish;
  end

  initial
  begin : watchdog
    wait (cycleCount >= timeoutCycles);
    failureCount++;
    $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
    finishReport();
    $finish;
  end

endmodule
